//--- ifu_params.svh
// fetch unit macros: widths, cache geometry, fifo depth, reset pc, opcodes
`ifndef IFU_PARAMS_SVH
`define IFU_PARAMS_SVH

// byte address and instruction word widths
`define ADDR_WIDTH 32
`define INSTR_WIDTH 32

// icache geometry, direct mapped
// 4 words per line, 128 bit line
`define LINE_WORDS 4
`define NUM_SETS 16

// instruction fifo entries
`define FIFO_DEPTH 8

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// opcodes seen by the predecoder, instr[31:26]
// jump carries a 26 bit word offset
`define OP_JUMP 6'b000010
// conditional branch carries a 16 bit word offset
`define OP_BRANCH 6'b000100

`endif

//--- fetch_types_pkg.sv
// fetch-side types: address, instruction, fifo entry vector and its field offsets
`include "ifu_params.svh"

package fetch_types_pkg;

    typedef logic [`ADDR_WIDTH-1:0]  addr_t;  // byte address
    typedef logic [`INSTR_WIDTH-1:0] instr_t; // one instruction word

    // fifo entry layout, msb to lsb:
    // {instr, pc, is_branch, pred_taken, target}
    localparam int TARGET_LSB = 0;
    localparam int PRED_BIT   = TARGET_LSB + `ADDR_WIDTH;   // 1 = predicted taken
    localparam int BR_BIT     = PRED_BIT + 1;               // branch info valid
    localparam int PC_LSB     = BR_BIT + 1;
    localparam int INSTR_LSB  = PC_LSB + `ADDR_WIDTH;
    localparam int ENTRY_W    = INSTR_LSB + `INSTR_WIDTH;   // 98 bits

    // whole entry travels as one flat vector
    // slice with the offsets above
    typedef logic [ENTRY_W-1:0] fifo_entry_t;

    // ADDR_WIDTH must be wide enough for the sign extended jump offset
    localparam int JUMP_OFF_W = 26;
    localparam int BR_OFF_W   = 16;

endpackage

//--- mem_types_pkg.sv
// memory-side types: cache line, tag, index, address split and refill fsm states
`include "ifu_params.svh"

package mem_types_pkg;

    localparam int BYTE_BITS   = $clog2(`INSTR_WIDTH / 8);  // byte within word
    localparam int WORD_BITS   = $clog2(`LINE_WORDS);       // word within line
    localparam int OFFSET_BITS = BYTE_BITS + WORD_BITS;     // byte within line
    localparam int INDEX_BITS  = $clog2(`NUM_SETS);
    localparam int TAG_BITS    = `ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

    typedef logic [`LINE_WORDS*`INSTR_WIDTH-1:0] line_t;   // word 0 in the low bits
    typedef logic [TAG_BITS-1:0]                  tag_t;
    typedef logic [INDEX_BITS-1:0]                index_t;

    // four-phase refill handshake
    typedef enum logic [1:0] {
        IDLE,    // no refill, watching for a miss
        REQ,     // mem_req high, waiting on mem_ack
        RELEASE  // req dropped, waiting for ack to fall
    } refill_state_t;

endpackage

//--- fetch_if.sv
// fetch_if interface: pc stage to instruction fifo enqueue path with modports
`timescale 1ns/1ps

interface fetch_if;
    import fetch_types_pkg::*;

    logic        valid; // fetched entry present, from the pc stage
    logic        ready; // fifo not full
    fifo_entry_t entry; // instr, pc, branch info, target

    // push happens when valid && ready

    // pc stage side
    modport producer (
        output valid,
        output entry,
        input  ready
    );

    // fifo side
    modport consumer (
        input  valid,
        input  entry,
        output ready
    );

endinterface

//--- fetch_pc.sv
// fetch_pc module: pc register, next-pc mux, static branch predecode, enqueue control
`timescale 1ns/1ps
`include "ifu_params.svh"

module fetch_pc (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    recovery_valid,
    input  fetch_types_pkg::addr_t  recovery_pc,
    input  logic                    hit,
    input  fetch_types_pkg::instr_t instr,
    output fetch_types_pkg::addr_t  pc,
    fetch_if.producer               fetch
);
    import fetch_types_pkg::*;

    logic [5:0] opcode;
    logic       is_jump;
    logic       is_cond;
    logic       is_branch;
    logic       pred_taken;
    addr_t      pc_plus4;
    addr_t      jump_off;   // sign extended, already times 4
    addr_t      br_off;
    addr_t      target;
    logic       advance;    // instruction accepted this cycle
    addr_t      next_pc;

    // predecode
    assign opcode  = instr[`INSTR_WIDTH-1 -: 6];
    assign is_jump = (opcode == `OP_JUMP);
    assign is_cond = (opcode == `OP_BRANCH);

    assign pc_plus4 = pc + addr_t'(4);
    assign jump_off = {{(`ADDR_WIDTH-JUMP_OFF_W-2){instr[JUMP_OFF_W-1]}},
                       instr[JUMP_OFF_W-1:0], 2'b00};
    assign br_off   = {{(`ADDR_WIDTH-BR_OFF_W-2){instr[BR_OFF_W-1]}},
                       instr[BR_OFF_W-1:0], 2'b00};

    always_comb begin
        is_branch  = 1'b0;
        pred_taken = 1'b0;
        target     = '0;            // non-branch carries zero target
        if (is_jump) begin
            is_branch  = 1'b1;
            pred_taken = 1'b1;      // jumps always taken
            target     = pc_plus4 + jump_off;
        end else if (is_cond) begin
            is_branch  = 1'b1;
            pred_taken = instr[BR_OFF_W-1]; // backward taken, forward not
            target     = pc_plus4 + br_off;
        end
    end

    // stall when the cache misses or the fifo is full
    assign advance = hit && fetch.ready;

    always_comb begin
        if (recovery_valid)
            next_pc = recovery_pc;                  // backend redirect wins
        else if (!advance)
            next_pc = pc;                           // hold
        else if (pred_taken)
            next_pc = target;
        else
            next_pc = pc_plus4;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= addr_t'(`RESET_PC);
        else
            pc <= next_pc;
    end

    // enqueue side, fifo drops the push itself during recovery
    assign fetch.valid = hit;

    always_comb begin
        fetch.entry = '0;
        fetch.entry[INSTR_LSB +: `INSTR_WIDTH] = instr;
        fetch.entry[PC_LSB +: `ADDR_WIDTH]     = pc;
        fetch.entry[BR_BIT]                    = is_branch;
        fetch.entry[PRED_BIT]                  = pred_taken;
        fetch.entry[TARGET_LSB +: `ADDR_WIDTH] = target;
    end

    // recovery pc comes from the backend, predecoded targets from the program
    a_pc_aligned : assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00)
        else $error("fetch pc not word aligned: %h", pc);

endmodule

//--- icache.sv
// icache module: direct-mapped tag/valid/data arrays, hit and word select, refill fsm
`timescale 1ns/1ps
`include "ifu_params.svh"

module icache (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_types_pkg::addr_t  pc,
    output logic                    hit,
    output fetch_types_pkg::instr_t instr,
    output logic                    mem_req,
    output fetch_types_pkg::addr_t  mem_addr,
    input  logic                    mem_ack,
    input  mem_types_pkg::line_t    mem_data
);
    import fetch_types_pkg::*;
    import mem_types_pkg::*;

    // storage
    tag_t                  tag_arr  [`NUM_SETS];
    line_t                 data_arr [`NUM_SETS];
    logic [`NUM_SETS-1:0]  valid_arr;           // only state that needs reset

    // lookup fields of the current pc
    index_t                idx;
    tag_t                  pc_tag;
    logic [WORD_BITS-1:0]  word_sel;
    line_t                 rd_line;

    // refill
    refill_state_t         state;
    refill_state_t         state_nxt;
    addr_t                 miss_addr;           // line aligned, held through REQ
    index_t                fill_idx;
    tag_t                  fill_tag;
    logic                  fill_we;

    assign idx      = pc[OFFSET_BITS +: INDEX_BITS];    // pc[7:4]
    assign word_sel = pc[BYTE_BITS +: WORD_BITS];       // pc[3:2]
    assign pc_tag   = pc[`ADDR_WIDTH-1 -: TAG_BITS];

    // combinational read
    assign rd_line = data_arr[idx];
    assign hit     = valid_arr[idx] && (tag_arr[idx] == pc_tag);
    assign instr   = rd_line[word_sel*`INSTR_WIDTH +: `INSTR_WIDTH];

    assign fill_idx = miss_addr[OFFSET_BITS +: INDEX_BITS];
    assign fill_tag = miss_addr[`ADDR_WIDTH-1 -: TAG_BITS];
    assign fill_we  = (state == REQ) && mem_ack;        // line arrives

    // four-phase handshake
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (!hit) state_nxt = REQ;         // miss seen
            REQ:     if (mem_ack) state_nxt = RELEASE;  // drop req next edge
            RELEASE: if (!mem_ack) state_nxt = IDLE;    // ack gone, may req again
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            valid_arr <= '0;
        end else begin
            state <= state_nxt;
            if (fill_we)
                valid_arr[fill_idx] <= 1'b1;
        end
    end

    // miss address latched on the way into REQ
    always_ff @(posedge clk) begin
        if (state == IDLE && !hit)
            miss_addr <= {pc[`ADDR_WIDTH-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    end

    // arrays, written only by refill
    always_ff @(posedge clk) begin
        if (fill_we) begin
            data_arr[fill_idx] <= mem_data;
            tag_arr[fill_idx]  <= fill_tag;
        end
    end

    assign mem_req  = (state == REQ);
    assign mem_addr = miss_addr;

    // memory samples the address across the whole wait for ack
    a_addr_stable : assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_ack |=> $stable(mem_addr))
        else $error("mem_addr changed while waiting for ack");

    // phase 5: a new request only once the previous ack has fallen
    a_req_after_ack : assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_req) |-> !mem_ack)
        else $error("mem_req raised while mem_ack still high");

endmodule

//--- instr_fifo.sv
// circular instruction fifo module with flush and a valid/ready dispatch port
`timescale 1ns/1ps
`include "ifu_params.svh"

module instr_fifo (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         flush,
    fetch_if.consumer                    enq,
    input  logic                         dispatch_ready,
    output logic                         deq_valid,
    output fetch_types_pkg::fifo_entry_t deq_entry
);
    import fetch_types_pkg::*;

    localparam int PTR_W = $clog2(`FIFO_DEPTH);

    fifo_entry_t        buf_mem [`FIFO_DEPTH]; // entry payload
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;                 // 0..FIFO_DEPTH
    logic               full;
    logic               push;
    logic               pop;

    assign full      = (count == (PTR_W+1)'(`FIFO_DEPTH));
    assign enq.ready = !full;
    assign deq_valid = (count != '0);
    assign deq_entry = buf_mem[rd_ptr];       // head shown straight away

    // flush cancels both sides in the same cycle
    assign push = enq.valid && enq.ready && !flush;
    assign pop  = deq_valid && dispatch_ready && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;                     // empty with pointers realigned
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;      // power of 2 depth wraps
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            buf_mem[wr_ptr] <= enq.entry;
    end

    // a push at full or a pop at empty would leave count out of range
    a_count_range : assert property (@(posedge clk) disable iff (!rst_n)
        count <= (PTR_W+1)'(`FIFO_DEPTH))
        else $error("instruction fifo count out of range: %0d", count);

    // pointer distance tracks the count unless an entry was lost or doubled
    a_ptr_count : assert property (@(posedge clk) disable iff (!rst_n)
        wr_ptr == rd_ptr + count[PTR_W-1:0])
        else $error("instruction fifo pointers disagree with count");

endmodule

//--- ifu.sv
// ifu top module: pc stage, icache and instruction fifo wired to plain ports
`timescale 1ns/1ps
`include "ifu_params.svh"

module ifu (
    input  logic                    clk,
    input  logic                    rst_n,
    // backend redirect
    input  logic                    recovery_valid,
    input  fetch_types_pkg::addr_t  recovery_pc,
    // line refill, four-phase
    output logic                    mem_req,
    output fetch_types_pkg::addr_t  mem_addr,
    input  logic                    mem_ack,
    input  mem_types_pkg::line_t    mem_data,
    // dispatch
    input  logic                    dispatch_ready,
    output logic                    instr_valid,
    output fetch_types_pkg::instr_t instr_data,
    output fetch_types_pkg::addr_t  instr_pc,
    output logic                    instr_is_branch,
    output logic                    instr_pred_taken,
    output fetch_types_pkg::addr_t  instr_target
);
    import fetch_types_pkg::*;

    addr_t       pc;
    logic        hit;
    instr_t      instr;
    fifo_entry_t deq_entry;

    fetch_if fetch_bus ();   // pc stage -> fifo

    fetch_pc pc_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .recovery_valid (recovery_valid),
        .recovery_pc    (recovery_pc),
        .hit            (hit),
        .instr          (instr),
        .pc             (pc),
        .fetch          (fetch_bus)
    );

    icache icache_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .pc       (pc),
        .hit      (hit),
        .instr    (instr),
        .mem_req  (mem_req),
        .mem_addr (mem_addr),
        .mem_ack  (mem_ack),
        .mem_data (mem_data)
    );

    instr_fifo ififo (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (recovery_valid),   // wrong-path entries dropped
        .enq            (fetch_bus),
        .dispatch_ready (dispatch_ready),
        .deq_valid      (instr_valid),
        .deq_entry      (deq_entry)
    );

    // head entry split into dispatch fields
    assign instr_data       = deq_entry[INSTR_LSB +: `INSTR_WIDTH];
    assign instr_pc         = deq_entry[PC_LSB +: `ADDR_WIDTH];
    assign instr_is_branch  = deq_entry[BR_BIT];
    assign instr_pred_taken = deq_entry[PRED_BIT];
    assign instr_target     = deq_entry[TARGET_LSB +: `ADDR_WIDTH];

endmodule

//--- tb_ifu.sv
// tb_ifu testbench: program memory, line refill responder, reference fetch model, checks
`timescale 1ns/1ps
`include "ifu_params.svh"

module tb_ifu;
    import fetch_types_pkg::*;
    import mem_types_pkg::*;

    localparam int N_STRAIGHT = 600;   // dequeues per test
    localparam int N_BP       = 400;
    localparam int N_RECOV    = 600;
    // about 12 cycles per dequeue worst case, plus reset and drain
    localparam int MAX_CYCLES = (N_STRAIGHT + N_BP + N_RECOV) * 12 + 800;

    logic   clk;
    logic   rst_n;
    logic   recovery_valid;
    addr_t  recovery_pc;
    logic   mem_req;
    addr_t  mem_addr;
    logic   mem_ack;
    line_t  mem_data;
    logic   dispatch_ready;
    logic   instr_valid;
    instr_t instr_data;
    addr_t  instr_pc;
    logic   instr_is_branch;
    logic   instr_pred_taken;
    addr_t  instr_target;

    instr_t      prog [256];          // 1 KB program, aliased by addr[9:2]
    int unsigned gen_state;
    int unsigned stim_state;
    int unsigned resp_state;
    int          mode;                // 0 idle, 1 random ready, 2 long stalls, 3 recovery
    int          cycle_count;
    int          deq_count;
    int          refill_count;
    int          recov_count;
    int          err_reset;
    int          err_proto;
    int          err_seq;
    int          tests_passed;
    int          tests_failed;
    addr_t       model_pc;            // next pc the model expects at the head

    ifu dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;        // 4 ns period
    end

    function automatic int unsigned lcg_step(int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // whole line from the program array, word 0 in the low bits
    function automatic line_t line_at(addr_t a);
        return {prog[{a[9:4], 2'd3}], prog[{a[9:4], 2'd2}],
                prog[{a[9:4], 2'd1}], prog[{a[9:4], 2'd0}]};
    endfunction

    // static prediction: jumps taken, backward branches taken
    task automatic predict(input addr_t pc, output instr_t ins, output logic br,
                           output logic tk, output addr_t tgt, output addr_t nxt);
        int off;
        ins = prog[pc[9:2]];
        br  = 1'b0;
        tk  = 1'b0;
        tgt = '0;
        nxt = pc + 32'd4;
        if (ins[31:26] == `OP_JUMP) begin
            off = int'($signed(ins[25:0]));
            tgt = pc + 32'd4 + addr_t'(off * 4);
            br  = 1'b1;
            tk  = 1'b1;
            nxt = tgt;
        end else if (ins[31:26] == `OP_BRANCH) begin
            off = int'($signed(ins[15:0]));
            tgt = pc + 32'd4 + addr_t'(off * 4);
            br  = 1'b1;
            tk  = (off < 0);
            if (tk)
                nxt = tgt;
        end
    endtask

    task automatic compare_field(string name, logic [31:0] exp, logic [31:0] got);
        if (exp !== got) begin
            $display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, got);
            err_seq++;
        end
    endtask

    task automatic report_test(string name, int errs);
        if (errs == 0) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: FAILED with %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    // dispatch side and backend redirect
    initial begin
        int unsigned r;
        int          run_left;
        logic        stall_low;
        dispatch_ready = 1'b0;
        recovery_valid = 1'b0;
        recovery_pc    = '0;
        run_left       = 0;
        stall_low      = 1'b0;
        forever begin
            @(posedge clk);
            stim_state = lcg_step(stim_state);
            r = stim_state >> 8;
            recovery_valid <= 1'b0;
            if (mode == 0) begin
                dispatch_ready <= 1'b0;
            end else if (mode == 2) begin
                if (run_left == 0) begin
                    stall_low = !stall_low;
                    run_left  = stall_low ? 16 + int'(r % 24) : 4 + int'(r % 12);
                end
                run_left--;
                dispatch_ready <= !stall_low;
            end else if (mode == 3 && !recovery_valid && r % 32 == 0) begin
                recovery_valid <= 1'b1;
                recovery_pc    <= {22'd0, r[17:10], 2'b00};
                dispatch_ready <= 1'b0;   // no pop in the redirect cycle
            end else begin
                dispatch_ready <= (r % 4 != 0);
            end
        end
    end

    // refill responder, four-phase
    initial begin
        int wait_left;
        mem_ack   = 1'b0;
        mem_data  = '0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                mem_ack   <= 1'b0;
                wait_left = 0;
            end else if (mem_ack) begin
                if (!mem_req)
                    mem_ack <= 1'b0;      // phase 4
            end else if (mem_req) begin
                if (wait_left == 0) begin
                    resp_state = lcg_step(resp_state);
                    wait_left  = 1 + int'((resp_state >> 8) % 6);
                end
                wait_left--;
                if (wait_left == 0) begin
                    mem_ack  <= 1'b1;
                    mem_data <= line_at(mem_addr);
                end
            end
        end
    end

    // monitor, sampled on the falling edge
    initial begin
        instr_t e_ins;
        logic   e_br;
        logic   e_tk;
        addr_t  e_tgt;
        addr_t  e_nxt;
        logic   req_prev;
        logic   in_reset;
        logic   flushed;
        logic   redirect_pending;
        addr_t  redirect_pc;
        req_prev         = 1'b0;
        in_reset         = 1'b1;
        flushed          = 1'b0;
        redirect_pending = 1'b0;
        redirect_pc      = '0;
        model_pc         = `RESET_PC;
        forever begin
            @(negedge clk);
            if (!rst_n || in_reset) begin
                if (instr_valid || mem_req) begin
                    $display("reset: instr_valid or mem_req high at %0t", $time);
                    err_reset++;
                end
                in_reset = !rst_n;        // one more look right after release
            end else begin
                if (mem_req && mem_addr[3:0] != 4'd0) begin
                    $display("refill: mem_addr %h not line aligned at %0t", mem_addr, $time);
                    err_proto++;
                end
                if (mem_req && !req_prev) begin
                    if (mem_ack) begin
                        $display("refill: mem_req rose while mem_ack high at %0t", $time);
                        err_proto++;
                    end
                    refill_count++;
                    if (refill_count == 1 && mem_addr != (`RESET_PC & ~32'hf)) begin
                        $display("reset: first refill line %h misses RESET_PC", mem_addr);
                        err_reset++;
                    end
                end
                req_prev = mem_req;
                if (flushed && instr_valid) begin
                    $display("recovery: fifo not empty after flush at %0t", $time);
                    err_seq++;
                end
                flushed = recovery_valid;
                if (instr_valid && dispatch_ready) begin
                    predict(model_pc, e_ins, e_br, e_tk, e_tgt, e_nxt);
                    if (redirect_pending)
                        compare_field("instr_pc after recovery", redirect_pc, instr_pc);
                    compare_field("instr_data", e_ins, instr_data);
                    compare_field("instr_pc", model_pc, instr_pc);
                    compare_field("instr_is_branch", {31'd0, e_br}, {31'd0, instr_is_branch});
                    compare_field("instr_pred_taken", {31'd0, e_tk}, {31'd0, instr_pred_taken});
                    compare_field("instr_target", e_tgt, instr_target);
                    model_pc         = e_nxt;
                    redirect_pending = 1'b0;
                    deq_count++;
                end
                if (recovery_valid) begin
                    model_pc         = recovery_pc;   // model restarts with the dut
                    redirect_pc      = recovery_pc;
                    redirect_pending = 1'b1;
                    recov_count++;
                end
            end
        end
    end

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial begin
        int unsigned r;
        int          off;
        instr_t      w;
        int          errs_start;
        rst_n     = 1'b0;
        mode      = 0;
        gen_state = 32'd8;
        for (int i = 0; i < 256; i++) begin
            gen_state = lcg_step(gen_state);
            r = gen_state >> 8;
            if (r % 16 < 2) begin                    // about 1 in 8 branches
                off = int'((r >> 4) % 17) - 8;
                w   = {`OP_BRANCH, r[23:14], off[15:0]};
            end else if (r % 16 == 2) begin          // 1 in 16 jumps
                off = int'((r >> 4) % 65) - 32;
                w   = {`OP_JUMP, off[25:0]};
            end else begin
                gen_state = lcg_step(gen_state);
                w = {1'b1, gen_state[30:0]};         // opcode never matches
            end
            prog[i] = w;
        end
        stim_state = lcg_step(gen_state);
        resp_state = lcg_step(stim_state);

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        while (refill_count < 1)
            @(posedge clk);
        report_test("reset_state", err_reset);

        errs_start = err_seq;
        mode = 1;
        while (deq_count < N_STRAIGHT)
            @(posedge clk);
        report_test("straight_fetch", err_seq - errs_start);

        errs_start = err_seq;
        mode = 2;
        while (deq_count < N_STRAIGHT + N_BP)
            @(posedge clk);
        report_test("back_pressure", err_seq - errs_start);

        errs_start = err_seq;
        mode = 3;
        while (deq_count < N_STRAIGHT + N_BP + N_RECOV)
            @(posedge clk);
        if (recov_count == 0) begin
            $display("recovery: no redirect was issued during the test");
            err_seq++;
        end
        report_test("recovery", err_seq - errs_start);

        if (refill_count < 2) begin
            $display("refill: only %0d refills seen", refill_count);
            err_proto++;
        end
        $display("refills seen: %0d", refill_count);
        report_test("refill_protocol", err_proto);

        $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

//--- ifu.f
+incdir+.
fetch_types_pkg.sv
mem_types_pkg.sv
fetch_if.sv
fetch_pc.sv
icache.sv
instr_fifo.sv
ifu.sv
tb_ifu.sv

//--- run_sim.sh
#!/bin/sh
# build the fetch unit testbench with Verilator and run it
# pass or fail comes from the simulation log

rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ifu -f ifu.f -o tb_ifu_sim > build.log 2>&1 \
    && ./obj_dir/tb_ifu_sim > sim.log 2>&1

grep -qx "sim passed" sim.log 2>/dev/null \
    && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }
